// ==== Bender.yml ====
package:
  name: spi_master

dependencies: {}

sources:
  # synthesizable design, package first
  - files:
      - logic/spi_master_pkg.sv
      - logic/spi_clock_gen.sv
      - logic/spi_shift_engine.sv
      - logic/spi_transfer_ctrl.sv
      - logic/spi_master_top.sv

  # simulation only
  - target: test
    files:
      - verification/spi_master_props.sv
      - verification/tb_spi_master.sv

// ==== all.f ====
logic/spi_master_pkg.sv
logic/spi_clock_gen.sv
logic/spi_shift_engine.sv
logic/spi_transfer_ctrl.sv
logic/spi_master_top.sv
verification/spi_master_props.sv
verification/tb_spi_master.sv

// ==== logic/spi_clock_gen.sv ====
// spi serial clock generator
// divides sclk into spi_clk and flags the leading and trailing transitions
`timescale 1ns/1ps
`default_nettype none

module spi_clock_gen
  import spi_master_pkg::*;
#(
  parameter int DIV_WIDTH = 8
) (
  input  logic sclk,
  input  logic rst,
  input  logic clk_run,
  input  logic cpol,
  input  div_t div,
  output logic spi_clk,
  output logic lead_edge,
  output logic trail_edge
);

  // --------------------
  // half period counter
  // --------------------

  // counts sclk cycles inside one half period
  logic [DIV_WIDTH-1:0] half_cnt;
  // terminal count, div minus one
  logic [DIV_WIDTH-1:0] half_last;
  // 0 at idle level, 1 away from it
  logic                 phase;
  // spi_clk moves at the coming edge
  logic                 toggle;

  assign half_last = DIV_WIDTH'(div) - 1'b1;
  assign toggle    = clk_run && (half_cnt == half_last);

  always_ff @(posedge sclk) begin
    if (rst) begin
      half_cnt <= '0;
    end else if (!clk_run || toggle) begin
      // restart each half period
      half_cnt <= '0;
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

  // --------------------
  // phase and strobes
  // --------------------

  // strobes are registered next to phase
  // so each one is high in the cycle spi_clk shows its new level
  always_ff @(posedge sclk) begin
    if (rst) begin
      phase      <= 1'b0;
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
    end else if (!clk_run) begin
      // back to idle level, no strobes
      phase      <= 1'b0;
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
    end else if (toggle) begin
      phase      <= ~phase;
      // leaving idle level
      lead_edge  <= ~phase;
      // returning to idle level
      trail_edge <= phase;
    end else begin
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
    end
  end

  // xor of two flops
  // cpol only moves while idle, with phase held at 0
  // so spi_clk follows the latched cpol from the start edge on
  assign spi_clk = phase ^ cpol;

endmodule

`default_nettype wire

// ==== logic/spi_master_pkg.sv ====
// spi master shared definitions
// per-transfer config struct, width types and controller states
`default_nettype none

package spi_master_pkg;

  // --------------------
  // width types
  // --------------------

  // serial clock half period in sclk cycles
  // 2 or more keeps mosi settled a cycle ahead of the capture edge
  typedef logic [7:0] div_t;

  // cs setup or hold wait in sclk cycles
  typedef logic [3:0] dly_t;

  // --------------------
  // transfer config
  // --------------------

  // latched once per transfer on an accepted start, 20 bits
  typedef struct packed {
    // idle level of spi_clk
    logic       cpol;
    // 0 samples on the leading edge, 1 on the trailing edge
    logic       cpha;
    div_t       div;
    // cs_n falling to first leading edge
    dly_t       cs_lead;
    // last trailing edge to cs_n rising
    dly_t       cs_trail;
    // selects one of up to 4 slaves
    logic [1:0] slave_idx;
  } spi_cfg_t;

  // --------------------
  // controller states
  // --------------------
  typedef enum logic [2:0] {
    st_idle,
    st_lead,
    st_shift,
    st_trail,
    st_gap
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== logic/spi_master_top.sv ====
// spi master top level
// controller, serial clock generator and shift engine on the external pins
`timescale 1ns/1ps
`default_nettype none

module spi_master_top
  import spi_master_pkg::*;
#(
  parameter int DATA_WIDTH = 8,
  // at most 4, bounded by slave_idx
  parameter int NUM_SLAVES = 4,
  parameter int DIV_WIDTH  = 8
) (
  input  logic                  sclk,
  input  logic                  rst,
  // request side
  input  logic                  start,
  input  spi_cfg_t              cfg,
  input  logic [DATA_WIDTH-1:0] tx_data,
  output logic                  busy,
  output logic                  done,
  output logic [DATA_WIDTH-1:0] rx_data,
  // spi pins
  output logic [NUM_SLAVES-1:0] cs_n,
  output logic                  spi_clk,
  output logic                  mosi,
  input  logic                  miso
);

  // --------------------
  // internal wiring
  // --------------------
  spi_cfg_t              cfg_q;
  logic                  clk_run;
  logic                  load;
  logic [DATA_WIDTH-1:0] load_data;
  logic                  lead_edge;
  logic                  trail_edge;

  // sequencing and chip select
  spi_transfer_ctrl #(
    .DATA_WIDTH (DATA_WIDTH),
    .NUM_SLAVES (NUM_SLAVES)
  ) u_ctrl (
    .sclk       (sclk),
    .rst        (rst),
    .start      (start),
    .cfg        (cfg),
    .tx_data    (tx_data),
    .trail_edge (trail_edge),
    .busy       (busy),
    .done       (done),
    .clk_run    (clk_run),
    .load       (load),
    .load_data  (load_data),
    .cfg_q      (cfg_q),
    .cs_n       (cs_n)
  );

  // serial clock from the latched mode and divider
  spi_clock_gen #(
    .DIV_WIDTH (DIV_WIDTH)
  ) u_clk (
    .sclk       (sclk),
    .rst        (rst),
    .clk_run    (clk_run),
    .cpol       (cfg_q.cpol),
    .div        (cfg_q.div),
    .spi_clk    (spi_clk),
    .lead_edge  (lead_edge),
    .trail_edge (trail_edge)
  );

  // data path
  spi_shift_engine #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_shift (
    .sclk       (sclk),
    .rst        (rst),
    .load       (load),
    .load_data  (load_data),
    .cpha       (cfg_q.cpha),
    .lead_edge  (lead_edge),
    .trail_edge (trail_edge),
    .miso       (miso),
    .mosi       (mosi),
    .rx_data    (rx_data)
  );

endmodule

`default_nettype wire

// ==== logic/spi_shift_engine.sv ====
// spi shift engine
// drives mosi msb first and collects miso on the cpha capture edge
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  sclk,
  input  logic                  rst,
  input  logic                  load,
  input  logic [DATA_WIDTH-1:0] load_data,
  input  logic                  cpha,
  input  logic                  lead_edge,
  input  logic                  trail_edge,
  input  logic                  miso,
  output logic                  mosi,
  output logic [DATA_WIDTH-1:0] rx_data
);

  // --------------------
  // edge selection
  // --------------------

  // bits still to go out, msb at the top
  logic [DATA_WIDTH-1:0] tx_sr;
  // bits captured so far, newest at bit 0
  logic [DATA_WIDTH-1:0] rx_sr;
  logic                  mosi_q;
  logic                  shift_en;
  logic                  capture_en;

  // cpha 0 samples on lead and shifts on trail
  // cpha 1 shifts on lead and samples on trail
  assign shift_en   = cpha ? lead_edge : trail_edge;
  assign capture_en = cpha ? trail_edge : lead_edge;

  // --------------------
  // transmit
  // --------------------

  // cpha 0 puts the msb on mosi at load
  // so the register only holds the rest of the word
  always_ff @(posedge sclk) begin
    if (load) begin
      if (cpha) begin
        tx_sr <= load_data;
      end else begin
        tx_sr <= load_data << 1;
      end
    end else if (shift_en) begin
      tx_sr <= tx_sr << 1;
    end
  end

  // mosi pin register, low out of reset
  always_ff @(posedge sclk) begin
    if (rst) begin
      mosi_q <= 1'b0;
    end else if (load) begin
      // cpha 1 waits for the first leading edge
      mosi_q <= cpha ? 1'b0 : load_data[DATA_WIDTH-1];
    end else if (shift_en) begin
      mosi_q <= tx_sr[DATA_WIDTH-1];
    end
  end

  assign mosi = mosi_q;

  // --------------------
  // receive
  // --------------------

  // strobe lags the spi_clk transition by one sclk
  // miso from the slave is still stable at that point
  always_ff @(posedge sclk) begin
    if (capture_en) begin
      rx_sr <= {rx_sr[DATA_WIDTH-2:0], miso};
    end
  end

  // full word once the last capture edge has passed
  assign rx_data = rx_sr;

endmodule

`default_nettype wire

// ==== logic/spi_transfer_ctrl.sv ====
// spi transfer controller
// latches a request, owns chip select and sequences lead, shift and trail phases
`timescale 1ns/1ps
`default_nettype none

module spi_transfer_ctrl
  import spi_master_pkg::*;
#(
  parameter int DATA_WIDTH = 8,
  parameter int NUM_SLAVES = 4
) (
  input  logic                  sclk,
  input  logic                  rst,
  input  logic                  start,
  input  spi_cfg_t              cfg,
  input  logic [DATA_WIDTH-1:0] tx_data,
  input  logic                  trail_edge,
  output logic                  busy,
  output logic                  done,
  output logic                  clk_run,
  output logic                  load,
  output logic [DATA_WIDTH-1:0] load_data,
  output spi_cfg_t              cfg_q,
  output logic [NUM_SLAVES-1:0] cs_n
);

  // shared counter covers both delays and the bit count
  localparam int CNT_W = ($clog2(DATA_WIDTH) > 4) ? $clog2(DATA_WIDTH) : 4;

  ctrl_state_t           state_q;
  ctrl_state_t           state_d;
  logic [CNT_W-1:0]      cnt_q;
  logic [CNT_W-1:0]      cnt_d;
  logic [DATA_WIDTH-1:0] data_q;
  logic [NUM_SLAVES-1:0] sel_n;
  logic                  accept;
  logic                  lead_done;
  logic                  last_bit;
  logic                  trail_done;
  logic                  cs_act;

  // --------------------
  // phase end conditions
  // --------------------

  // starts while busy are dropped
  assign accept     = (state_q == st_idle) && start;
  // cs_lead + 1 cycles in st_lead, cs_n falls after the first
  assign lead_done  = (cnt_q == CNT_W'(cfg_q.cs_lead));
  // DATA_WIDTH-th trailing edge
  assign last_bit   = trail_edge && (cnt_q == CNT_W'(DATA_WIDTH - 1));
  assign trail_done = (cnt_q == CNT_W'(cfg_q.cs_trail));

  // --------------------
  // state machine
  // --------------------
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      st_idle: begin
        if (start) begin
          state_d = st_lead;
          cnt_d   = '0;
        end
      end
      st_lead: begin
        if (lead_done) begin
          state_d = st_shift;
          cnt_d   = '0;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      st_shift: begin
        // one count per trailing edge
        if (last_bit) begin
          state_d = st_trail;
          cnt_d   = '0;
        end else if (trail_edge) begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      st_trail: begin
        if (trail_done) begin
          state_d = st_gap;
        end else begin
          cnt_d = cnt_q + 1'b1;
        end
      end
      // single dead cycle, done is high here
      st_gap:  state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge sclk) begin
    if (rst) begin
      state_q <= st_idle;
      cnt_q   <= '0;
      cfg_q   <= '0;
      cs_n    <= '1;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (accept) begin
        cfg_q <= cfg;
      end
      cs_n <= cs_act ? sel_n : '1;
    end
  end

  // transmit word, only read after load
  always_ff @(posedge sclk) begin
    if (accept) begin
      data_q <= tx_data;
    end
  end

  // --------------------
  // chip select
  // --------------------

  // one low bit for the latched slave
  always_comb begin
    for (int i = 0; i < NUM_SLAVES; i++) begin
      sel_n[i] = (cfg_q.slave_idx != 2'(i));
    end
  end

  // falls one cycle after the start edge, once spi_clk sits at the new cpol
  // rises on the edge into st_gap, together with done
  assign cs_act = (state_q == st_lead) || (state_q == st_shift) ||
                  ((state_q == st_trail) && !trail_done);

  // --------------------
  // outputs
  // --------------------
  assign busy      = (state_q == st_lead) || (state_q == st_shift) || (state_q == st_trail);
  assign done      = (state_q == st_gap);
  // dropped in the last trailing strobe cycle so no extra edge starts
  assign clk_run   = (state_q == st_shift) && !last_bit;
  // first st_lead cycle
  assign load      = (state_q == st_lead) && (cnt_q == '0);
  assign load_data = data_q;

endmodule

`default_nettype wire

// ==== verification/spi_master_patterns.hex ====
// bits 35:16 cfg (cpol cpha div[7:0] cs_lead[3:0] cs_trail[3:0] slave_idx[1:0])
// bits 15:8 master word, bits 7:0 slave word
00800A53C
40C495AC3
81086FF00
C08CF00FF
017C1817E
4203E0180
841D38001
C83FC6996
019161234
41E475678
828649ABC
C3199DEF0
0088B0FF0
40800AA55
80D5D55AA
C530EC71D
07E20E24B
808023DD3
424ED7788
C128BB16E

// ==== verification/spi_master_props.sv ====
// spi master protocol properties
// bound into the top level, watches chip select, idle clock level and mosi timing
`timescale 1ns/1ps
`default_nettype none

module spi_master_props
  import spi_master_pkg::*;
#(
  parameter int NUM_SLAVES = 4
) (
  input wire logic                  sclk,
  input wire logic                  rst,
  input wire logic [NUM_SLAVES-1:0] cs_n,
  input wire logic                  spi_clk,
  input wire logic                  mosi,
  input wire spi_cfg_t              cfg_q,
  input wire logic                  lead_edge,
  input wire logic                  trail_edge
);

  // failed assertions so far, read by the testbench at the end
  int   assert_fails = 0;
  // high in the cycle after a capture transition of spi_clk
  logic capture;

  assign capture = cfg_q.cpha ? trail_edge : lead_edge;

  // --------------------
  // properties
  // --------------------

  // never more than one slave selected
  a_one_cs : assert property (@(posedge sclk) disable iff (rst)
    $countones(~cs_n) <= 1)
    else begin
      $error("more than one chip select is low");
      assert_fails++;
    end

  // no slave selected, so the clock rests at the latched mode
  a_idle_clk : assert property (@(posedge sclk) disable iff (rst)
    (&cs_n) |-> (spi_clk == cfg_q.cpol))
    else begin
      $error("serial clock left its idle level with no slave selected");
      assert_fails++;
    end

  // data held across the sampling transition
  a_mosi_stable : assert property (@(posedge sclk) disable iff (rst)
    capture |-> $stable(mosi))
    else begin
      $error("mosi moved on a capture edge");
      assert_fails++;
    end

endmodule

bind spi_master_top spi_master_props #(
  .NUM_SLAVES (NUM_SLAVES)
) u_props (
  .sclk       (sclk),
  .rst        (rst),
  .cs_n       (cs_n),
  .spi_clk    (spi_clk),
  .mosi       (mosi),
  .cfg_q      (cfg_q),
  .lead_edge  (lead_edge),
  .trail_edge (trail_edge)
);

`default_nettype wire

// ==== verification/tb_spi_master.sv ====
// spi master testbench
// pattern driven transfers against a behavioral slave in all four modes
// checks loopback data, chip select, edge count and transfer timing
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master
  import spi_master_pkg::*;
;

  localparam int DATA_WIDTH = 8;
  localparam int NUM_SLAVES = 4;
  localparam int DIV_WIDTH  = 8;
  localparam int NUM_PAT    = 20;
  localparam int PERIOD_NS  = 40;
  // worst case for one transfer plus its idle gap
  localparam int MAX_CYCLES = 600;
  localparam longint WATCHDOG_NS = (longint'(NUM_PAT) * MAX_CYCLES + 40) * PERIOD_NS;

  logic                  sclk;
  logic                  rst;
  logic                  start;
  spi_cfg_t              cfg;
  logic [DATA_WIDTH-1:0] tx_data;
  logic                  busy;
  logic                  done;
  logic [DATA_WIDTH-1:0] rx_data;
  logic [NUM_SLAVES-1:0] cs_n;
  logic                  spi_clk;
  logic                  mosi;
  logic                  miso;

  // cfg, master word, slave word
  logic [20+2*DATA_WIDTH-1:0] patterns [0:NUM_PAT-1];

  int                    errors = 0;
  int                    checks = 0;
  int                    done_count = 0;
  logic [15:0]           lfsr = 16'd45758;
  // mode of the running transfer for the slave model
  spi_cfg_t              cur_cfg = '0;
  logic [DATA_WIDTH-1:0] slave_word = '0;
  logic [DATA_WIDTH-1:0] slave_sr = '0;
  logic [DATA_WIDTH-1:0] slave_rx = '0;
  int                    lead_cnt = 0;
  logic                  active_q = 1'b0;
  logic                  clk_q = 1'b0;

  spi_master_top #(
    .DATA_WIDTH (DATA_WIDTH),
    .NUM_SLAVES (NUM_SLAVES),
    .DIV_WIDTH  (DIV_WIDTH)
  ) u_dut (
    .sclk    (sclk),
    .rst     (rst),
    .start   (start),
    .cfg     (cfg),
    .tx_data (tx_data),
    .busy    (busy),
    .done    (done),
    .rx_data (rx_data),
    .cs_n    (cs_n),
    .spi_clk (spi_clk),
    .mosi    (mosi),
    .miso    (miso)
  );

  // --------------------
  // helpers
  // --------------------

  task automatic compare_values(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0d ns %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic draw_random(input int nbits, output int val);
    val = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | lfsr[0];
    end
  endtask

  // --------------------
  // clock and watchdog
  // --------------------
  initial begin
    sclk = 1'b0;
    forever #(PERIOD_NS / 2) sclk = ~sclk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, transfers did not complete", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

  always @(posedge sclk) begin
    #2;
    if (done) done_count++;
  end

  // --------------------
  // behavioral slave
  // --------------------

  // looks at the pins 2 ns after each edge with the master's mode rules
  always @(posedge sclk) begin : slave_model
    logic                  active;
    logic                  leading;
    logic [NUM_SLAVES-1:0] exp_cs;
    #2;
    active = !(&cs_n);
    if (active) begin
      exp_cs = ~(NUM_SLAVES'(1) << cur_cfg.slave_idx);
      compare_values("cs_n during transfer", cs_n, exp_cs);
    end
    if (active && !active_q) begin
      // cpha 0 shows the msb right at frame start
      slave_sr = slave_word;
      slave_rx = '0;
      lead_cnt = 0;
      if (!cur_cfg.cpha) begin
        miso     = slave_sr[DATA_WIDTH-1];
        slave_sr = slave_sr << 1;
      end
    end else if (active && (spi_clk !== clk_q)) begin
      leading = (spi_clk != cur_cfg.cpol);
      if (leading) lead_cnt++;
      // cpha 0 captures on lead, cpha 1 on trail
      if (leading != cur_cfg.cpha) begin
        slave_rx = {slave_rx[DATA_WIDTH-2:0], mosi};
      end else begin
        miso     = slave_sr[DATA_WIDTH-1];
        slave_sr = slave_sr << 1;
      end
    end
    active_q = active;
    clk_q    = spi_clk;
  end

  // --------------------
  // transfers
  // --------------------

  // idle cycles with the clock parked at the last mode and nothing selected
  task automatic idle_gap(input int len);
    repeat (len + 1) begin
      @(posedge sclk);
      #2;
      compare_values("done in idle", done, 1'b0);
      compare_values("busy in idle", busy, 1'b0);
      compare_values("cs_n in idle", cs_n, {NUM_SLAVES{1'b1}});
      compare_values("spi_clk idle level", spi_clk, cur_cfg.cpol);
    end
  endtask

  // called 2 ns after an edge with the DUT idle
  task automatic run_transfer(input int idx);
    spi_cfg_t              c;
    logic [DATA_WIDTH-1:0] mw;
    logic [DATA_WIDTH-1:0] sw;
    int                    expected;
    int                    cycles;
    int                    busy_cycles;
    int                    poke_at;
    bit                    seen_done;
    {c, mw, sw} = patterns[idx];
    cur_cfg     = c;
    slave_word  = sw;
    // lead phase, shift phase with its stop cycle, trail phase
    expected = (int'(c.cs_lead) + 1) + (2 * int'(c.div) * DATA_WIDTH + 1) +
               (int'(c.cs_trail) + 1);
    // odd patterns get a stray start a bit into the shift phase
    poke_at = (idx % 2) ? int'(c.cs_lead) + 2 * int'(c.div) + 2 : -1;
    start       = 1'b1;
    cfg         = c;
    tx_data     = mw;
    cycles      = 0;
    busy_cycles = 0;
    seen_done   = 1'b0;
    while (!seen_done && cycles <= MAX_CYCLES) begin
      @(posedge sclk);
      #2;
      start   = 1'b0;
      cfg     = ~c;
      tx_data = ~mw;
      if (done) begin
        seen_done = 1'b1;
      end else begin
        cycles++;
        if (busy) busy_cycles++;
        if (cycles == poke_at) start = 1'b1;
      end
    end
    if (!seen_done) begin
      errors++;
      $display("transfer %0d never signalled done within %0d cycles", idx, MAX_CYCLES);
    end else begin
      compare_values("start to done cycles", cycles, expected);
      compare_values("busy cycles", busy_cycles, expected);
      compare_values("busy with done", busy, 1'b0);
      compare_values("cs_n at done", cs_n, {NUM_SLAVES{1'b1}});
      compare_values("rx_data", rx_data, sw);
      compare_values("slave captured word", slave_rx, mw);
      compare_values("leading edges", lead_cnt, DATA_WIDTH);
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int gap;
    rst     = 1'b1;
    start   = 1'b0;
    cfg     = '0;
    tx_data = '0;
    miso    = 1'b0;
    $readmemh("verification/spi_master_patterns.hex", patterns);
    if ($isunknown(patterns[NUM_PAT-1])) begin
      errors++;
      $display("pattern file is missing or holds fewer than %0d lines", NUM_PAT);
    end
    repeat (16) @(posedge sclk);
    #2;
    rst = 1'b0;
    @(posedge sclk);
    #2;
    compare_values("cs_n after reset", cs_n, {NUM_SLAVES{1'b1}});
    compare_values("busy after reset", busy, 1'b0);
    compare_values("done after reset", done, 1'b0);
    compare_values("mosi after reset", mosi, 1'b0);
    compare_values("spi_clk after reset", spi_clk, 1'b0);
    for (int i = 0; i < NUM_PAT; i++) begin
      draw_random(3, gap);
      idle_gap(gap);
      run_transfer(i);
    end
    idle_gap(2);
    // stray starts must not add a done
    compare_values("done pulses", done_count, NUM_PAT);
    errors = errors + u_dut.u_props.assert_fails;
    $display("checks %0d errors %0d assertion failures %0d",
             checks, errors, u_dut.u_props.assert_fails);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
